// File: include/bpred_settings.svh
`ifndef BPRED_SETTINGS_SVH
`define BPRED_SETTINGS_SVH

// global history length, sizes the gshare and chooser tables
`define BPRED_GHR_W 10

// per-PC local history table
`define BPRED_BHT_DEPTH 256
`define BPRED_BHT_IDX_W $clog2(`BPRED_BHT_DEPTH)

// local history length, sizes the local pattern table
`define BPRED_LHR_W 8

// direct-mapped target buffer
`define BPRED_BTB_DEPTH 64
`define BPRED_BTB_IDX_W $clog2(`BPRED_BTB_DEPTH)
`define BPRED_BTB_TAG_W 8

// weakly not taken, or weakly prefers local in the chooser
`define BPRED_CTR_INIT 2'b01

`endif

// File: logic/bpred_pkg.sv
`include "bpred_settings.svh"

package bpred_pkg;

    // two-bit saturating counter, one step toward up/down
    function automatic logic [1:0] ctr_step(input logic [1:0] ctr, input logic up);
        logic [1:0] nxt;
        nxt = ctr;
        if (up && ctr != 2'b11) begin
            nxt = ctr + 2'd1;
        end else if (!up && ctr != 2'b00) begin
            nxt = ctr - 2'd1;
        end
        return nxt;
    endfunction

    // high bit gives the direction
    function automatic logic ctr_taken(input logic [1:0] ctr);
        return ctr[1];
    endfunction

    // local history table index, word-aligned PC bits
    function automatic logic [`BPRED_BHT_IDX_W-1:0] bht_hash(input logic [31:0] pc);
        return pc[2 +: `BPRED_BHT_IDX_W];
    endfunction

    // gshare index, shared by the global pattern table and the chooser
    function automatic logic [`BPRED_GHR_W-1:0] gshare_hash(
        input logic [`BPRED_GHR_W-1:0] ghr,
        input logic [31:0]             pc
    );
        return ghr ^ pc[2 +: `BPRED_GHR_W];
    endfunction

endpackage

// File: logic/local_hist_predictor.sv
`timescale 1ns/1ps
`include "bpred_settings.svh"

module local_hist_predictor (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [31:0]                 lookup_pc_i,
    output logic [31:0]                 pc_dly_o,
    output logic [`BPRED_BHT_IDX_W-1:0] bht_idx_o,
    output logic [`BPRED_LHR_W-1:0]     lpht_idx_o,
    output logic                        local_taken_o,
    input  logic                        commit_valid_i,
    input  logic [`BPRED_BHT_IDX_W-1:0] commit_bht_idx_i,
    input  logic [`BPRED_LHR_W-1:0]     commit_lpht_idx_i,
    input  logic                        commit_taken_i
);
    import bpred_pkg::*;

    localparam int LPHT_DEPTH = 1 << `BPRED_LHR_W;

    // per-PC history and the pattern counters it selects
    logic [`BPRED_LHR_W-1:0]     bht [`BPRED_BHT_DEPTH];
    logic [1:0]                  lpht [LPHT_DEPTH];

    logic [`BPRED_BHT_IDX_W-1:0] lookup_bht_idx;
    logic [31:0]                 pc_q;
    logic [`BPRED_BHT_IDX_W-1:0] bht_idx_q;
    logic [`BPRED_LHR_W-1:0]     hist_q;

    assign lookup_bht_idx = bht_hash(lookup_pc_i);

    // stage one, history read with the PC alongside
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q      <= '0;
            bht_idx_q <= '0;
            hist_q    <= '0;
        end else begin
            pc_q      <= lookup_pc_i;
            bht_idx_q <= lookup_bht_idx;
            hist_q    <= bht[lookup_bht_idx];
        end
    end

    // stage two, history picks the counter
    assign pc_dly_o      = pc_q;
    assign bht_idx_o     = bht_idx_q;
    assign lpht_idx_o    = hist_q;
    assign local_taken_o = ctr_taken(lpht[hist_q]);

    // commit training, old value seen by a same-cycle read
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `BPRED_BHT_DEPTH; i++) begin
                bht[i] <= '0;
            end
            for (int i = 0; i < LPHT_DEPTH; i++) begin
                lpht[i] <= `BPRED_CTR_INIT;
            end
        end else if (commit_valid_i) begin
            bht[commit_bht_idx_i] <= {bht[commit_bht_idx_i][`BPRED_LHR_W-2:0],
                                      commit_taken_i};
            lpht[commit_lpht_idx_i] <= ctr_step(lpht[commit_lpht_idx_i], commit_taken_i);
        end
    end

endmodule

// File: logic/global_hist_predictor.sv
`timescale 1ns/1ps
`include "bpred_settings.svh"

module global_hist_predictor (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    recover_i,
    input  logic [31:0]             lookup_pc_i,
    input  logic                    spec_shift_i,
    input  logic                    spec_bit_i,
    output logic [`BPRED_GHR_W-1:0] gpht_idx_o,
    output logic                    global_taken_o,
    input  logic                    commit_valid_i,
    input  logic [`BPRED_GHR_W-1:0] commit_gpht_idx_i,
    input  logic                    commit_taken_i
);
    import bpred_pkg::*;

    localparam int GPHT_DEPTH = 1 << `BPRED_GHR_W;

    logic [`BPRED_GHR_W-1:0] spec_ghr;
    logic [`BPRED_GHR_W-1:0] commit_ghr;
    logic [1:0]              gpht [GPHT_DEPTH];
    logic [`BPRED_GHR_W-1:0] idx_q;

    // hash with the history as it stands at lookup
    always_ff @(posedge clk) begin
        if (rst) begin
            idx_q <= '0;
        end else begin
            idx_q <= gshare_hash(spec_ghr, lookup_pc_i);
        end
    end

    assign gpht_idx_o     = idx_q;
    assign global_taken_o = ctr_taken(gpht[idx_q]);

    // speculative history, recover wins over a shift
    always_ff @(posedge clk) begin
        if (rst) begin
            spec_ghr <= '0;
        end else if (recover_i) begin
            spec_ghr <= commit_ghr;
        end else if (spec_shift_i) begin
            spec_ghr <= {spec_ghr[`BPRED_GHR_W-2:0], spec_bit_i};
        end
    end

    // architectural history, only moves on commit
    always_ff @(posedge clk) begin
        if (rst) begin
            commit_ghr <= '0;
        end else if (commit_valid_i) begin
            commit_ghr <= {commit_ghr[`BPRED_GHR_W-2:0], commit_taken_i};
        end
    end

    // gshare counters
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < GPHT_DEPTH; i++) begin
                gpht[i] <= `BPRED_CTR_INIT;
            end
        end else if (commit_valid_i) begin
            gpht[commit_gpht_idx_i] <= ctr_step(gpht[commit_gpht_idx_i], commit_taken_i);
        end
    end

endmodule

// File: logic/branch_target_buffer.sv
`timescale 1ns/1ps
`include "bpred_settings.svh"

module branch_target_buffer (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] lookup_pc_i,
    output logic        hit_o,
    output logic [31:0] target_o,
    input  logic        commit_valid_i,
    input  logic        commit_taken_i,
    input  logic [31:0] commit_pc_i,
    input  logic [31:0] commit_target_i
);

    localparam int IDX_LSB = 2;
    localparam int TAG_LSB = IDX_LSB + `BPRED_BTB_IDX_W;

    logic                       valid  [`BPRED_BTB_DEPTH];
    logic [`BPRED_BTB_TAG_W-1:0] tag    [`BPRED_BTB_DEPTH];
    logic [31:0]                target [`BPRED_BTB_DEPTH];

    logic [`BPRED_BTB_IDX_W-1:0] rd_idx;
    logic [`BPRED_BTB_TAG_W-1:0] rd_tag;
    logic [`BPRED_BTB_IDX_W-1:0] wr_idx;
    logic [`BPRED_BTB_TAG_W-1:0] wr_tag;
    logic                        wr_en;

    // index from bits 7:2, tag from the bits just above
    assign rd_idx = lookup_pc_i[IDX_LSB +: `BPRED_BTB_IDX_W];
    assign rd_tag = lookup_pc_i[TAG_LSB +: `BPRED_BTB_TAG_W];
    assign wr_idx = commit_pc_i[IDX_LSB +: `BPRED_BTB_IDX_W];
    assign wr_tag = commit_pc_i[TAG_LSB +: `BPRED_BTB_TAG_W];

    // only taken branches allocate
    assign wr_en = commit_valid_i & commit_taken_i;

    assign hit_o    = valid[rd_idx] && (tag[rd_idx] == rd_tag);
    assign target_o = target[rd_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `BPRED_BTB_DEPTH; i++) begin
                valid[i] <= 1'b0;
            end
        end else if (wr_en) begin
            valid[wr_idx] <= 1'b1;
        end
    end

    // tag and target storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag[wr_idx]    <= wr_tag;
            target[wr_idx] <= commit_target_i;
        end
    end

endmodule

// File: logic/branch_predictor.sv
`timescale 1ns/1ps
`include "bpred_settings.svh"

module branch_predictor (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        lookup_valid_i,
    input  logic [31:0]                 lookup_pc_i,
    input  logic                        lookup_is_br_i,
    input  logic                        lookup_is_jmp_i,
    input  logic                        commit_valid_i,
    input  logic [31:0]                 commit_pc_i,
    input  logic                        commit_taken_i,
    input  logic [31:0]                 commit_target_i,
    input  logic [`BPRED_BHT_IDX_W-1:0] commit_bht_idx_i,
    input  logic [`BPRED_LHR_W-1:0]     commit_lpht_idx_i,
    input  logic [`BPRED_GHR_W-1:0]     commit_gpht_idx_i,
    input  logic                        commit_local_taken_i,
    input  logic                        commit_global_taken_i,
    input  logic                        recover_i,
    output logic                        pred_valid_o,
    output logic                        pred_taken_o,
    output logic                        pred_hit_o,
    output logic [31:0]                 pred_target_o,
    output logic [`BPRED_BHT_IDX_W-1:0] pred_bht_idx_o,
    output logic [`BPRED_LHR_W-1:0]     pred_lpht_idx_o,
    output logic [`BPRED_GHR_W-1:0]     pred_gpht_idx_o,
    output logic                        pred_local_taken_o,
    output logic                        pred_global_taken_o
);
    import bpred_pkg::*;

    localparam int CPHT_DEPTH = 1 << `BPRED_GHR_W;

    logic [1:0]                  cpht [CPHT_DEPTH];
    logic                        s1_valid;
    logic                        s1_is_br;
    logic                        s1_is_jmp;
    logic [31:0]                 pc_dly;
    logic [`BPRED_BHT_IDX_W-1:0] bht_idx;
    logic [`BPRED_LHR_W-1:0]     lpht_idx;
    logic [`BPRED_GHR_W-1:0]     gpht_idx;
    logic                        local_taken;
    logic                        global_taken;
    logic                        btb_hit;
    logic [31:0]                 btb_target;
    logic                        use_global;
    logic                        sel_taken;
    logic                        spec_shift;
    logic                        spec_bit;
    logic                        local_ok;
    logic                        global_ok;

    local_hist_predictor u_local (
        .clk               (clk),
        .rst               (rst),
        .lookup_pc_i       (lookup_pc_i),
        .pc_dly_o          (pc_dly),
        .bht_idx_o         (bht_idx),
        .lpht_idx_o        (lpht_idx),
        .local_taken_o     (local_taken),
        .commit_valid_i    (commit_valid_i),
        .commit_bht_idx_i  (commit_bht_idx_i),
        .commit_lpht_idx_i (commit_lpht_idx_i),
        .commit_taken_i    (commit_taken_i)
    );

    global_hist_predictor u_global (
        .clk               (clk),
        .rst               (rst),
        .recover_i         (recover_i),
        .lookup_pc_i       (lookup_pc_i),
        .spec_shift_i      (spec_shift),
        .spec_bit_i        (spec_bit),
        .gpht_idx_o        (gpht_idx),
        .global_taken_o    (global_taken),
        .commit_valid_i    (commit_valid_i),
        .commit_gpht_idx_i (commit_gpht_idx_i),
        .commit_taken_i    (commit_taken_i)
    );

    // BTB reads the PC delayed by the local stage
    branch_target_buffer u_btb (
        .clk             (clk),
        .rst             (rst),
        .lookup_pc_i     (pc_dly),
        .hit_o           (btb_hit),
        .target_o        (btb_target),
        .commit_valid_i  (commit_valid_i),
        .commit_taken_i  (commit_taken_i),
        .commit_pc_i     (commit_pc_i),
        .commit_target_i (commit_target_i)
    );

    // lookup flags, one stage to line up with the table reads
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            s1_is_br  <= 1'b0;
            s1_is_jmp <= 1'b0;
        end else begin
            s1_valid  <= lookup_valid_i;
            s1_is_br  <= lookup_is_br_i;
            s1_is_jmp <= lookup_is_jmp_i;
        end
    end

    // chooser high bit set means trust gshare
    assign use_global = ctr_taken(cpht[gpht_idx]);
    assign sel_taken  = use_global ? global_taken : local_taken;

    // jumps always push a one into the history
    assign spec_shift = s1_valid & (s1_is_br | s1_is_jmp);
    assign spec_bit   = s1_is_jmp | sel_taken;

    assign local_ok  = (commit_local_taken_i == commit_taken_i);
    assign global_ok = (commit_global_taken_i == commit_taken_i);

    // chooser only moves when exactly one side was right
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < CPHT_DEPTH; i++) begin
                cpht[i] <= `BPRED_CTR_INIT;
            end
        end else if (commit_valid_i && (local_ok != global_ok)) begin
            cpht[commit_gpht_idx_i] <= ctr_step(cpht[commit_gpht_idx_i], global_ok);
        end
    end

    // t+2 outputs, taken and hit qualified by valid
    always_ff @(posedge clk) begin
        if (rst) begin
            pred_valid_o <= 1'b0;
            pred_taken_o <= 1'b0;
            pred_hit_o   <= 1'b0;
        end else begin
            pred_valid_o <= s1_valid;
            pred_taken_o <= s1_valid & sel_taken;
            pred_hit_o   <= s1_valid & btb_hit;
        end
    end

    // target and metadata carried down the pipe
    always_ff @(posedge clk) begin
        pred_target_o       <= btb_target;
        pred_bht_idx_o      <= bht_idx;
        pred_lpht_idx_o     <= lpht_idx;
        pred_gpht_idx_o     <= gpht_idx;
        pred_local_taken_o  <= local_taken;
        pred_global_taken_o <= global_taken;
    end

endmodule

// File: verification/bpred_checker.sv
`timescale 1ns/1ps

module bpred_checker (
    input logic clk,
    input logic rst,
    input logic lookup_valid_i,
    input logic pred_valid_i,
    input logic pred_taken_i,
    input logic pred_hit_i
);

    int fail_count = 0;

    // outputs cleared by reset
    assert property (@(posedge clk) rst |=> (!pred_valid_i && !pred_taken_i && !pred_hit_i))
        else begin
            $error("prediction outputs not cleared after reset");
            fail_count++;
        end

    // fixed two-cycle lookup latency
    assert property (@(posedge clk) disable iff (rst) lookup_valid_i |-> ##2 pred_valid_i)
        else begin
            $error("no prediction two cycles after lookup");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (rst) pred_hit_i |-> pred_valid_i)
        else begin
            $error("btb hit flagged without a valid prediction");
            fail_count++;
        end

endmodule

bind branch_predictor bpred_checker u_checker (
    .clk            (clk),
    .rst            (rst),
    .lookup_valid_i (lookup_valid_i),
    .pred_valid_i   (pred_valid_o),
    .pred_taken_i   (pred_taken_o),
    .pred_hit_i     (pred_hit_o)
);

// File: verification/bpred_monitor.sv
`timescale 1ns/1ps
`include "bpred_settings.svh"

module bpred_monitor (
    input logic                        clk,
    input logic                        rst,
    input logic                        pred_valid_i,
    input logic                        pred_taken_i,
    input logic                        pred_hit_i,
    input logic [31:0]                 pred_target_i,
    input logic [`BPRED_BHT_IDX_W-1:0] pred_bht_idx_i,
    input logic [`BPRED_LHR_W-1:0]     pred_lpht_idx_i,
    input logic [`BPRED_GHR_W-1:0]     pred_gpht_idx_i,
    input logic                        pred_local_taken_i,
    input logic                        pred_global_taken_i
);

    // field positions within one queued expectation, target at the bottom
    localparam int GIDX_LSB  = 32;
    localparam int BIDX_LSB  = GIDX_LSB + `BPRED_GHR_W;
    localparam int LIDX_LSB  = BIDX_LSB + `BPRED_BHT_IDX_W;
    localparam int TAKEN_BIT = LIDX_LSB + `BPRED_LHR_W;
    localparam int HIT_BIT   = TAKEN_BIT + 1;
    localparam int LT_BIT    = TAKEN_BIT + 2;
    localparam int GT_BIT    = TAKEN_BIT + 3;
    localparam int EXP_W     = TAKEN_BIT + 4;

    logic [EXP_W-1:0] exp_q [$];
    int error_count = 0;

    task automatic expect_result(input logic taken, input logic hit,
                                 input logic [31:0] target,
                                 input logic [`BPRED_BHT_IDX_W-1:0] bidx,
                                 input logic [`BPRED_LHR_W-1:0] lidx,
                                 input logic [`BPRED_GHR_W-1:0] gidx,
                                 input logic local_taken, input logic global_taken);
        exp_q.push_back({global_taken, local_taken, hit, taken, lidx, bidx, gidx, target});
    endtask

    function automatic int pending_count();
        return exp_q.size();
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
            error_count++;
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin : sample
        logic [EXP_W-1:0] e;
        if (!rst && pred_valid_i) begin
            if (exp_q.size() == 0) begin
                $display("error at %0t ns: prediction arrived with no lookup outstanding", $time);
                error_count++;
            end else begin
                e = exp_q.pop_front();
                compare_field("pred_taken_o", 32'(pred_taken_i), 32'(e[TAKEN_BIT]));
                compare_field("pred_hit_o", 32'(pred_hit_i), 32'(e[HIT_BIT]));
                compare_field("pred_bht_idx_o", 32'(pred_bht_idx_i),
                              32'(e[BIDX_LSB +: `BPRED_BHT_IDX_W]));
                compare_field("pred_lpht_idx_o", 32'(pred_lpht_idx_i),
                              32'(e[LIDX_LSB +: `BPRED_LHR_W]));
                compare_field("pred_gpht_idx_o", 32'(pred_gpht_idx_i),
                              32'(e[GIDX_LSB +: `BPRED_GHR_W]));
                compare_field("pred_local_taken_o", 32'(pred_local_taken_i), 32'(e[LT_BIT]));
                compare_field("pred_global_taken_o", 32'(pred_global_taken_i),
                              32'(e[GT_BIT]));
                // target only meaningful on a hit
                if (e[HIT_BIT]) begin
                    compare_field("pred_target_o", pred_target_i, e[31:0]);
                end
            end
        end
    end

endmodule

// File: verification/bpred_tb.sv
`timescale 1ns/1ps
`include "bpred_settings.svh"

module bpred_tb;

    localparam int MAX_ROWS   = 24;
    localparam int CLK_PERIOD = 8;
    localparam logic [1:0] OP_LOOKUP  = 2'd0;
    localparam logic [1:0] OP_COMMIT  = 2'd1;
    localparam logic [1:0] OP_RECOVER = 2'd2;
    localparam logic [31:0] PC_A = 32'h0000_1000;
    localparam logic [31:0] PC_B = 32'h0000_1010;
    localparam logic [31:0] PC_C = 32'h0000_1020;
    localparam logic [31:0] PC_D = 32'h0000_1024;

    logic clk, rst;
    logic lookup_valid_i, lookup_is_br_i, lookup_is_jmp_i;
    logic [31:0] lookup_pc_i;
    logic commit_valid_i, commit_taken_i, recover_i;
    logic [31:0] commit_pc_i, commit_target_i;
    logic [`BPRED_BHT_IDX_W-1:0] commit_bht_idx_i;
    logic [`BPRED_LHR_W-1:0] commit_lpht_idx_i;
    logic [`BPRED_GHR_W-1:0] commit_gpht_idx_i;
    logic commit_local_taken_i, commit_global_taken_i;
    logic pred_valid_o, pred_taken_o, pred_hit_o;
    logic [31:0] pred_target_o;
    logic [`BPRED_BHT_IDX_W-1:0] pred_bht_idx_o;
    logic [`BPRED_LHR_W-1:0] pred_lpht_idx_o;
    logic [`BPRED_GHR_W-1:0] pred_gpht_idx_o;
    logic pred_local_taken_o, pred_global_taken_o;

    // one table row per cycle
    logic [1:0] t_op [MAX_ROWS];
    logic [31:0] t_pc [MAX_ROWS];
    logic t_br [MAX_ROWS];
    logic t_jmp [MAX_ROWS];
    logic t_out [MAX_ROWS];
    logic [31:0] t_tgt [MAX_ROWS];
    logic [`BPRED_LHR_W-1:0] t_lidx [MAX_ROWS];
    logic [`BPRED_GHR_W-1:0] t_gidx [MAX_ROWS];
    logic t_lt [MAX_ROWS];
    logic t_gt [MAX_ROWS];
    logic t_exp_taken [MAX_ROWS];
    logic t_exp_hit [MAX_ROWS];
    logic [31:0] t_exp_tgt [MAX_ROWS];
    logic [`BPRED_LHR_W-1:0] t_exp_lidx [MAX_ROWS];
    logic t_exp_lt [MAX_ROWS];
    logic t_exp_gt [MAX_ROWS];
    int n_rows = 0;

    // speculative and committed history model
    logic [`BPRED_GHR_W-1:0] spec_m, cghr_m, next_spec, exp_gidx;
    logic pend_shift, pend_bit;

    branch_predictor UUT (.*);

    bpred_monitor mon (
        .clk                 (clk),
        .rst                 (rst),
        .pred_valid_i        (pred_valid_o),
        .pred_taken_i        (pred_taken_o),
        .pred_hit_i          (pred_hit_o),
        .pred_target_i       (pred_target_o),
        .pred_bht_idx_i      (pred_bht_idx_o),
        .pred_lpht_idx_i     (pred_lpht_idx_o),
        .pred_gpht_idx_i     (pred_gpht_idx_o),
        .pred_local_taken_i  (pred_local_taken_o),
        .pred_global_taken_i (pred_global_taken_o)
    );

    task automatic add_lookup(input logic [31:0] pc, input logic br, input logic jmp,
                              input logic taken, input logic hit, input logic [31:0] tgt,
                              input logic [`BPRED_LHR_W-1:0] lidx, input logic lt,
                              input logic gt);
        t_op[n_rows] = OP_LOOKUP;
        t_pc[n_rows] = pc;
        t_br[n_rows] = br;
        t_jmp[n_rows] = jmp;
        t_out[n_rows] = 1'b0;
        t_tgt[n_rows] = '0;
        t_lidx[n_rows] = '0;
        t_gidx[n_rows] = '0;
        t_lt[n_rows] = 1'b0;
        t_gt[n_rows] = 1'b0;
        t_exp_taken[n_rows] = taken;
        t_exp_hit[n_rows] = hit;
        t_exp_tgt[n_rows] = tgt;
        t_exp_lidx[n_rows] = lidx;
        t_exp_lt[n_rows] = lt;
        t_exp_gt[n_rows] = gt;
        n_rows++;
    endtask

    task automatic add_commit(input logic [31:0] pc, input logic taken, input logic [31:0] tgt,
                              input logic [`BPRED_LHR_W-1:0] lidx,
                              input logic [`BPRED_GHR_W-1:0] gidx, input logic lt, input logic gt);
        add_lookup(pc, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0, 1'b0, 1'b0);
        t_op[n_rows-1] = OP_COMMIT;
        t_out[n_rows-1] = taken;
        t_tgt[n_rows-1] = tgt;
        t_lidx[n_rows-1] = lidx;
        t_gidx[n_rows-1] = gidx;
        t_lt[n_rows-1] = lt;
        t_gt[n_rows-1] = gt;
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        rnd = $urandom;
        add_lookup(PC_A, 0, 0, 0, 0, '0, 8'h00, 0, 0);
        add_commit(PC_A, 1, 32'h2000, 8'h80, 10'h155, 0, 0);
        add_lookup(PC_A, 0, 0, 0, 1, 32'h2000, 8'h01, 0, 0);
        // random PC whose BTB slot and local history are untouched
        add_lookup({rnd[31:10], 8'hc8, 2'b00}, 0, 0, 0, 0, '0, 8'h00, 0, 0);
        add_commit(PC_A, 0, 32'h3000, 8'h81, 10'h156, 0, 0);
        add_lookup(PC_A, 0, 0, 0, 1, 32'h2000, 8'h02, 0, 0);
        add_commit(PC_B, 1, 32'h4000, 8'h03, 10'h157, 0, 0);
        add_commit(PC_B, 1, 32'h4000, 8'h03, 10'h157, 0, 0);
        add_lookup(PC_B, 0, 0, 1, 1, 32'h4000, 8'h03, 1, 0);
        // only gshare right so the chooser at index 8 leans global
        add_commit(PC_D, 1, 32'h5000, 8'h05, 10'h008, 0, 1);
        add_commit(PC_D, 1, 32'h5000, 8'h05, 10'h008, 0, 1);
        add_lookup(PC_C, 0, 0, 1, 0, '0, 8'h00, 0, 1);
        add_lookup(PC_C, 1, 0, 1, 0, '0, 8'h00, 0, 1);
        add_lookup(PC_C, 1, 0, 1, 0, '0, 8'h00, 0, 1);
        add_lookup(PC_C, 0, 0, 0, 0, '0, 8'h00, 0, 0);
        add_lookup('0, 0, 0, 0, 0, '0, 8'h00, 0, 0);
        t_op[n_rows-1] = OP_RECOVER;
        add_lookup(PC_C, 0, 0, 0, 0, '0, 8'h00, 0, 0);
        add_lookup(PC_A, 0, 1, 0, 1, 32'h2000, 8'h02, 0, 0);
        add_lookup(PC_A, 0, 0, 0, 1, 32'h2000, 8'h02, 0, 0);
        add_lookup(PC_A, 0, 0, 0, 1, 32'h2000, 8'h02, 0, 0);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((2 * MAX_ROWS + 40) * CLK_PERIOD);
        $display("timeout: predictions still outstanding when the watchdog expired");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        lookup_valid_i = 0;
        lookup_pc_i = '0;
        lookup_is_br_i = 0;
        lookup_is_jmp_i = 0;
        commit_valid_i = 0;
        commit_pc_i = '0;
        commit_taken_i = 0;
        commit_target_i = '0;
        commit_bht_idx_i = '0;
        commit_lpht_idx_i = '0;
        commit_gpht_idx_i = '0;
        commit_local_taken_i = 0;
        commit_global_taken_i = 0;
        recover_i = 0;
        spec_m = '0;
        cghr_m = '0;
        pend_shift = 0;
        pend_bit = 0;
        void'($urandom(32'hc5b7));
        build_table();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int r = 0; r < n_rows; r++) begin
            @(posedge clk);
            lookup_valid_i <= (t_op[r] == OP_LOOKUP);
            lookup_pc_i <= t_pc[r];
            lookup_is_br_i <= t_br[r];
            lookup_is_jmp_i <= t_jmp[r];
            commit_valid_i <= (t_op[r] == OP_COMMIT);
            commit_pc_i <= t_pc[r];
            commit_taken_i <= t_out[r];
            commit_target_i <= t_tgt[r];
            commit_bht_idx_i <= t_pc[r][9:2];
            commit_lpht_idx_i <= t_lidx[r];
            commit_gpht_idx_i <= t_gidx[r];
            commit_local_taken_i <= t_lt[r];
            commit_global_taken_i <= t_gt[r];
            recover_i <= (t_op[r] == OP_RECOVER);
            if (t_op[r] == OP_LOOKUP) begin
                exp_gidx = spec_m ^ t_pc[r][11:2];
                mon.expect_result(t_exp_taken[r], t_exp_hit[r], t_exp_tgt[r], t_pc[r][9:2],
                                  t_exp_lidx[r], exp_gidx, t_exp_lt[r], t_exp_gt[r]);
            end
            // a lookup's shift lands two cycles later
            next_spec = spec_m;
            if (t_op[r] == OP_RECOVER) begin
                next_spec = cghr_m;
            end else if (pend_shift) begin
                next_spec = {spec_m[`BPRED_GHR_W-2:0], pend_bit};
            end
            pend_shift = (t_op[r] == OP_LOOKUP) && (t_br[r] || t_jmp[r]);
            pend_bit = t_jmp[r] | t_exp_taken[r];
            if (t_op[r] == OP_COMMIT) begin
                cghr_m = {cghr_m[`BPRED_GHR_W-2:0], t_out[r]};
            end
            spec_m = next_spec;
        end
        @(posedge clk);
        lookup_valid_i <= 1'b0;
        commit_valid_i <= 1'b0;
        recover_i <= 1'b0;
        while (mon.pending_count() > 0) @(posedge clk);
        repeat (2) @(posedge clk);
        $display("errors: %0d mismatches and %0d assertion failures over %0d rows",
                 mon.error_count, UUT.u_checker.fail_count, n_rows);
        if (mon.error_count == 0 && UUT.u_checker.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
logic/bpred_pkg.sv
logic/local_hist_predictor.sv
logic/global_hist_predictor.sv
logic/branch_target_buffer.sv
logic/branch_predictor.sv
verification/bpred_checker.sv
verification/bpred_monitor.sv
verification/bpred_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= bpred_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL CHECKS PASSED

SOURCES := $(wildcard logic/*.sv verification/*.sv include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
